// File: rtl/e0c_pkg.sv
package e0c_pkg;

  typedef logic [11:0] instr_t;
  typedef logic [3:0] nibble_t;

  // bit order matches the SET/RST F mask.
  typedef struct packed {
    logic d;
    logic z;
    logic c;
  } flags_t;

  typedef enum logic [1:0] {reg_a, reg_b, reg_mx, reg_my} reg_code_t;

  typedef enum logic [3:0] {
    op_add, op_adc, op_sub, op_ld_imm, op_ld_x, op_ld_y,
    op_set_f, op_rst_f, op_jp, op_halt, op_nop
  } op_kind_t;

  localparam instr_t opc_add_rq = 12'hA80;
  localparam instr_t opc_adc_rq = 12'hA90;
  localparam instr_t opc_sub_rq = 12'hAA0;
  localparam instr_t opc_add_ri = 12'hC00;
  localparam instr_t opc_adc_ri = 12'hC40;
  localparam instr_t opc_ld_ri  = 12'hE00;
  localparam instr_t opc_ld_x   = 12'hB00;
  localparam instr_t opc_ld_y   = 12'h800;
  localparam instr_t opc_jp     = 12'h000;
  localparam instr_t opc_set_f  = 12'hF40;
  localparam instr_t opc_rst_f  = 12'hF50;
  localparam instr_t opc_halt   = 12'hFF8;

  localparam int instr_cycles = 7;

  localparam logic [11:0] addr_ctrl      = 12'h000;
  localparam logic [11:0] addr_status    = 12'h004;
  localparam logic [11:0] addr_ab        = 12'h008;
  localparam logic [11:0] addr_x         = 12'h00C;
  localparam logic [11:0] addr_y         = 12'h010;
  localparam logic [11:0] addr_pc        = 12'h014;
  localparam logic [11:0] addr_flags     = 12'h018;
  localparam logic [11:0] addr_retired   = 12'h01C;
  localparam logic [11:0] addr_prog_base = 12'h400;
  localparam logic [11:0] addr_data_base = 12'h800;

endpackage

// File: rtl/e0c_mem_if.sv
`timescale 1ns/10ps

interface e0c_mem_if #(
  parameter type word_t = logic,
  parameter int addr_w = 8
) ();

  logic              en;
  logic              we;
  logic [addr_w-1:0] addr;
  word_t             wdata;
  word_t             rdata;  // valid one clock after en.

  modport host (output en, we, addr, wdata, input rdata);
  modport mem (input en, we, addr, wdata, output rdata);

endinterface

// File: rtl/e0c_mem.sv
`timescale 1ns/10ps

module e0c_mem #(
  parameter type word_t = logic,
  parameter int addr_w = 8
) (
  input logic    clk,
  e0c_mem_if.mem port
);

  word_t store [2**addr_w];

  always_ff @(posedge clk) begin
    if (port.en) begin
      if (port.we) begin
        store[port.addr] <= port.wdata;
      end
      port.rdata <= store[port.addr];  // old word on a write.
    end
  end

endmodule

// File: rtl/e0c_alu.sv
`timescale 1ns/10ps

module e0c_alu (
  input  e0c_pkg::nibble_t a,
  input  e0c_pkg::nibble_t b,
  input  logic             carry_in,
  input  logic             subtract,
  input  logic             decimal,
  output e0c_pkg::nibble_t result,
  output logic             carry,
  output logic             zero
);

  logic [4:0] sum;
  logic [4:0] diff;

  assign sum  = {1'b0, a} + {1'b0, b} + 5'(carry_in);
  assign diff = {1'b0, a} - {1'b0, b} - 5'(carry_in);

  always_comb begin
    if (subtract) begin
      carry = diff[4];  // borrow.
      if (decimal && diff[4]) begin
        result = diff[3:0] + 4'd10;
      end else begin
        result = diff[3:0];
      end
    end else if (decimal && sum >= 5'd10) begin
      // bcd digit overflow.
      carry  = 1'b1;
      result = 4'(sum - 5'd10);
    end else begin
      carry  = sum[4];
      result = sum[3:0];
    end
  end

  assign zero = (result == 4'h0);

endmodule

// File: rtl/e0c_regs.sv
`timescale 1ns/10ps

module e0c_regs #(
  parameter int prog_addr_w = 8
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   a_we,
  input  logic                   b_we,
  input  logic                   x_we,
  input  logic                   y_we,
  input  logic                   pc_we,
  input  logic                   flags_we,
  input  e0c_pkg::nibble_t       nibble_wdata,
  input  logic [7:0]             byte_wdata,
  input  logic [prog_addr_w-1:0] pc_wdata,
  input  e0c_pkg::flags_t        flags_wdata,
  output e0c_pkg::nibble_t       a,
  output e0c_pkg::nibble_t       b,
  output logic [11:0]            x,
  output logic [11:0]            y,
  output logic [prog_addr_w-1:0] pc,
  output e0c_pkg::flags_t        flags
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      a     <= '0;
      b     <= '0;
      x     <= '0;
      y     <= '0;
      pc    <= '0;
      flags <= '0;
    end else begin
      if (a_we) begin
        a <= nibble_wdata;
      end
      if (b_we) begin
        b <= nibble_wdata;
      end
      // byte load clears the page nibble.
      if (x_we) begin
        x <= {4'h0, byte_wdata};
      end
      if (y_we) begin
        y <= {4'h0, byte_wdata};
      end
      if (pc_we) begin
        pc <= pc_wdata;
      end
      if (flags_we) begin
        flags <= flags_wdata;
      end
    end
  end

endmodule

// File: rtl/e0c_core.sv
`timescale 1ns/10ps

module e0c_core #(
  parameter int prog_addr_w = 8,
  parameter int data_addr_w = 8
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   run_req,
  output logic                   running,
  output logic                   halted,
  output logic [15:0]            retired,
  e0c_mem_if.host                prog,
  e0c_mem_if.host                data,
  input  e0c_pkg::nibble_t       a,
  input  e0c_pkg::nibble_t       b,
  input  logic [11:0]            x,
  input  logic [11:0]            y,
  input  logic [prog_addr_w-1:0] pc,
  input  e0c_pkg::flags_t        flags,
  output logic                   a_we,
  output logic                   b_we,
  output logic                   x_we,
  output logic                   y_we,
  output logic                   pc_we,
  output logic                   flags_we,
  output e0c_pkg::nibble_t       nibble_wdata,
  output logic [7:0]             byte_wdata,
  output logic [prog_addr_w-1:0] pc_wdata,
  output e0c_pkg::flags_t        flags_wdata
);

  import e0c_pkg::*;

  logic [2:0] phase;
  logic       run_req_q;
  instr_t     ir;
  op_kind_t   kind;
  reg_code_t  r_code;
  reg_code_t  q_code;
  nibble_t    imm;
  nibble_t    opr;
  nibble_t    opq;
  nibble_t    res;
  nibble_t    alu_res;
  logic       use_imm;
  logic       arith;
  logic       writes_r;
  logic       wb;
  logic       last;
  logic       start;
  logic       alu_c;
  logic       alu_z;
  logic       res_c;
  logic       res_z;

  function automatic nibble_t operand(reg_code_t code);
    case (code)
      reg_a:   return a;
      reg_b:   return b;
      default: return data.rdata;
    endcase
  endfunction

  function automatic logic [data_addr_w-1:0] ram_addr(reg_code_t code);
    return data_addr_w'(code == reg_mx ? x : y);
  endfunction

  always_comb begin
    kind    = op_nop;
    use_imm = 1'b0;
    r_code  = reg_code_t'(ir[3:2]);
    q_code  = reg_code_t'(ir[1:0]);
    imm     = ir[3:0];
    if (ir[11:4] == opc_add_rq[11:4]) kind = op_add;
    else if (ir[11:4] == opc_adc_rq[11:4]) kind = op_adc;
    else if (ir[11:4] == opc_sub_rq[11:4]) kind = op_sub;
    else if (ir[11:6] == opc_add_ri[11:6]) kind = op_add;
    else if (ir[11:6] == opc_adc_ri[11:6]) kind = op_adc;
    else if (ir[11:6] == opc_ld_ri[11:6]) kind = op_ld_imm;
    else if (ir[11:8] == opc_ld_x[11:8]) kind = op_ld_x;
    else if (ir[11:8] == opc_ld_y[11:8]) kind = op_ld_y;
    else if (ir[11:8] == opc_jp[11:8]) kind = op_jp;
    else if (ir == opc_halt) kind = op_halt;
    else if (ir[11:4] == opc_set_f[11:4]) kind = op_set_f;
    else if (ir[11:4] == opc_rst_f[11:4]) kind = op_rst_f;
    if (ir[11:10] == 2'b11) begin
      use_imm = 1'b1;  // r,i forms keep r in bits 5:4.
      r_code  = reg_code_t'(ir[5:4]);
    end
  end

  assign arith    = kind inside {op_add, op_adc, op_sub};
  assign writes_r = arith || kind == op_ld_imm;
  assign last     = (phase == 3'(instr_cycles - 1));
  assign start    = run_req && !run_req_q && !running;
  assign wb       = running && phase == 3'd5;
  assign opq      = use_imm ? imm : operand(q_code);

  e0c_alu alu (
    .a        (opr),
    .b        (opq),
    .carry_in (kind == op_adc && flags.c),
    .subtract (kind == op_sub),
    .decimal  (flags.d),
    .result   (alu_res),
    .carry    (alu_c),
    .zero     (alu_z)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      running   <= 1'b0;
      halted    <= 1'b0;
      phase     <= '0;
      retired   <= '0;
      run_req_q <= 1'b0;
    end else begin
      run_req_q <= run_req;
      if (start) begin
        running <= 1'b1;
        halted  <= 1'b0;
        phase   <= '0;
        retired <= '0;
      end else if (running) begin
        if (last) begin
          phase   <= '0;
          retired <= retired + 16'd1;
          if (kind == op_halt) begin
            running <= 1'b0;
            halted  <= 1'b1;
          end else if (!run_req) begin
            running <= 1'b0;  // stop between instructions.
          end
        end else begin
          phase <= phase + 3'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (running && phase == 3'd1) ir <= prog.rdata;
    if (running && phase == 3'd3) opr <= operand(r_code);
    if (running && phase == 3'd4) begin
      res   <= (kind == op_ld_imm) ? imm : alu_res;
      res_c <= alu_c;
      res_z <= alu_z;
    end
  end

  always_comb begin
    prog.en    = running && phase == 3'd0;
    prog.we    = 1'b0;
    prog.addr  = pc;
    prog.wdata = '0;
    data.en    = 1'b0;
    data.we    = 1'b0;
    data.addr  = ram_addr(r_code);
    data.wdata = res;
    if (running && arith && phase == 3'd2 && r_code[1]) data.en = 1'b1;
    if (running && arith && phase == 3'd3 && !use_imm && q_code[1]) begin
      data.en   = 1'b1;
      data.addr = ram_addr(q_code);
    end
    if (wb && writes_r && r_code[1]) begin
      data.en = 1'b1;
      data.we = 1'b1;
    end
  end

  assign a_we         = wb && writes_r && r_code == reg_a;
  assign b_we         = wb && writes_r && r_code == reg_b;
  assign x_we         = wb && kind == op_ld_x;
  assign y_we         = wb && kind == op_ld_y;
  assign flags_we     = wb && (arith || kind == op_set_f || kind == op_rst_f);
  assign nibble_wdata = res;
  assign byte_wdata   = ir[7:0];

  always_comb begin
    flags_wdata = flags;
    if (kind == op_set_f) flags_wdata = flags_t'(flags | ir[2:0]);
    if (kind == op_rst_f) flags_wdata = flags_t'(flags & ~ir[2:0]);
    if (arith) begin
      flags_wdata.c = res_c;
      flags_wdata.z = res_z;
    end
  end

  // every run starts at address zero.
  assign pc_we    = start || (running && last);
  assign pc_wdata = start ? '0 : (kind == op_jp) ? prog_addr_w'(ir[7:0]) : pc + 1'b1;

endmodule

// File: rtl/e0c_apb_host.sv
`timescale 1ns/10ps

module e0c_apb_host #(
  parameter int prog_addr_w = 8,
  parameter int data_addr_w = 8
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [11:0]            paddr,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   run_req,
  input  logic                   running,
  input  logic                   halted,
  input  e0c_pkg::nibble_t       a,
  input  e0c_pkg::nibble_t       b,
  input  logic [11:0]            x,
  input  logic [11:0]            y,
  input  logic [prog_addr_w-1:0] pc,
  input  e0c_pkg::flags_t        flags,
  input  logic [15:0]            retired,
  e0c_mem_if.host                prog,
  e0c_mem_if.host                data
);

  import e0c_pkg::*;

  logic halted_q;
  logic is_prog;
  logic is_data;
  logic access;
  logic mem_go;

  assign is_prog = paddr[11:10] == addr_prog_base[11:10];
  assign is_data = paddr[11:10] == addr_data_base[11:10];
  assign access  = psel && penable;
  assign mem_go  = psel && (penable ? pwrite : !pwrite);  // read in setup.
  assign pready  = 1'b1;
  assign pslverr = access && running && (is_prog || is_data);

  assign prog.en    = mem_go && is_prog;
  assign prog.we    = access && pwrite;
  assign prog.addr  = paddr[prog_addr_w+1:2];
  assign prog.wdata = instr_t'(pwdata[11:0]);
  assign data.en    = mem_go && is_data;
  assign data.we    = access && pwrite;
  assign data.addr  = paddr[data_addr_w+1:2];
  assign data.wdata = pwdata[3:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run_req  <= 1'b0;
      halted_q <= 1'b0;
    end else begin
      halted_q <= halted;
      if (access && pwrite && paddr == addr_ctrl) begin
        run_req <= pwdata[0];
      end else if (halted && !halted_q) begin
        run_req <= 1'b0;  // drop run on halt.
      end
    end
  end

  always_comb begin
    prdata = '0;
    if (is_prog) prdata = 32'(prog.rdata);
    else if (is_data) prdata = 32'(data.rdata);
    else begin
      case (paddr)
        addr_ctrl:    prdata = 32'(run_req);
        addr_status:  prdata = {30'b0, halted, running};
        addr_ab:      prdata = {24'b0, b, a};
        addr_x:       prdata = 32'(x);
        addr_y:       prdata = 32'(y);
        addr_pc:      prdata = 32'(pc);
        addr_flags:   prdata = 32'(flags);
        addr_retired: prdata = 32'(retired);
        default:      prdata = '0;
      endcase
    end
  end

endmodule

// File: rtl/e0c_cpu.sv
`timescale 1ns/10ps

module e0c_cpu #(
  parameter int prog_addr_w = 8,
  parameter int data_addr_w = 8
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [11:0] paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  import e0c_pkg::*;

  logic                   run_req;
  logic                   running;
  logic                   halted;
  logic [15:0]            retired;
  nibble_t                a;
  nibble_t                b;
  logic [11:0]            x;
  logic [11:0]            y;
  logic [prog_addr_w-1:0] pc;
  flags_t                 flags;
  logic                   a_we;
  logic                   b_we;
  logic                   x_we;
  logic                   y_we;
  logic                   pc_we;
  logic                   flags_we;
  nibble_t                nibble_wdata;
  logic [7:0]             byte_wdata;
  logic [prog_addr_w-1:0] pc_wdata;
  flags_t                 flags_wdata;

  e0c_mem_if #(.word_t(instr_t), .addr_w(prog_addr_w)) core_prog (), apb_prog (), prog_bus ();
  e0c_mem_if #(.word_t(nibble_t), .addr_w(data_addr_w)) core_data (), apb_data (), data_bus ();

  // core owns both buses while running.
  assign prog_bus.en     = running ? core_prog.en : apb_prog.en;
  assign prog_bus.we     = running ? core_prog.we : apb_prog.we;
  assign prog_bus.addr   = running ? core_prog.addr : apb_prog.addr;
  assign prog_bus.wdata  = running ? core_prog.wdata : apb_prog.wdata;
  assign core_prog.rdata = prog_bus.rdata;
  assign apb_prog.rdata  = prog_bus.rdata;

  assign data_bus.en     = running ? core_data.en : apb_data.en;
  assign data_bus.we     = running ? core_data.we : apb_data.we;
  assign data_bus.addr   = running ? core_data.addr : apb_data.addr;
  assign data_bus.wdata  = running ? core_data.wdata : apb_data.wdata;
  assign core_data.rdata = data_bus.rdata;
  assign apb_data.rdata  = data_bus.rdata;

  e0c_mem #(.word_t(instr_t), .addr_w(prog_addr_w)) prog_mem (
    .clk  (clk),
    .port (prog_bus.mem)
  );

  e0c_mem #(.word_t(nibble_t), .addr_w(data_addr_w)) data_mem (
    .clk  (clk),
    .port (data_bus.mem)
  );

  e0c_regs #(.prog_addr_w(prog_addr_w)) regs (
    .clk, .rst_n,
    .a_we, .b_we, .x_we, .y_we, .pc_we, .flags_we,
    .nibble_wdata, .byte_wdata, .pc_wdata, .flags_wdata,
    .a, .b, .x, .y, .pc, .flags
  );

  e0c_core #(.prog_addr_w(prog_addr_w), .data_addr_w(data_addr_w)) core (
    .clk, .rst_n, .run_req, .running, .halted, .retired,
    .prog (core_prog.host),
    .data (core_data.host),
    .a, .b, .x, .y, .pc, .flags,
    .a_we, .b_we, .x_we, .y_we, .pc_we, .flags_we,
    .nibble_wdata, .byte_wdata, .pc_wdata, .flags_wdata
  );

  e0c_apb_host #(.prog_addr_w(prog_addr_w), .data_addr_w(data_addr_w)) apb (
    .clk, .rst_n,
    .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
    .run_req, .running, .halted,
    .a, .b, .x, .y, .pc, .flags, .retired,
    .prog (apb_prog.host),
    .data (apb_data.host)
  );

endmodule

// File: tests/e0c_cpu_tb.sv
`timescale 1ns/10ps

module e0c_cpu_tb;

  import e0c_pkg::*;

  localparam int clk_period = 100;
  localparam int cycles_per_instr = 7;
  localparam int max_prog_len = 10;
  localparam int n_programs = 2 * (3 * 16 + 2 * 4) + 2;
  localparam int apb_clocks = 3 * (max_prog_len + 14);  // load, start, polls and readback.
  localparam int timeout_ns = n_programs * (max_prog_len * cycles_per_instr + apb_clocks)
                              * clk_period + 1000 * clk_period;
  // clocks after the run write when retired is sampled.
  localparam int probe_pts[5] = '{6, 14, 20, 28, 34};

  logic        clk = 1'b0;
  logic        rst_n;
  logic [11:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  logic [31:0] lfsr_state = 32'he5ea6426;
  logic [11:0] prog_words[$];

  e0c_cpu #(.prog_addr_w(8), .data_addr_w(8)) UUT (
    .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr
  );

  always #(clk_period / 2) clk = ~clk;

  initial begin
    #(timeout_ns);
    $display("timeout: the core did not finish the programs in the expected time");
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [3:0] operand_value(input logic bcd);
    return bcd ? 4'(take_bits(4) % 10) : 4'(take_bits(4));
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAIL %s expected %h got %h", name, exp, act);
      $display("Test failures found");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(negedge clk);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    rdata = prdata;
    err   = pslverr;
    check_value("pready", 32'h1, 32'(pready));
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, wdata, rd, err);
    check_value("pslverr", 32'h0, 32'(err));
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
    logic err;
    apb_access(1'b0, addr, 32'h0, data, err);
    check_value("pslverr", 32'h0, 32'(err));
  endtask

  task automatic read_expect(input string name, input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    apb_read(addr, rd);
    check_value(name, exp, rd);
  endtask

  task automatic load_program();
    for (int i = 0; i < prog_words.size(); i++) begin
      apb_write(addr_prog_base + 12'(i * 4), 32'(prog_words[i]));
    end
  endtask

  task automatic wait_halt();
    logic [31:0] st;
    st = '0;
    while (!st[1]) begin
      apb_read(addr_status, st);
    end
  endtask

  task automatic check_end(input int n_exec, input int halt_addr);
    read_expect("status", addr_status, 32'h2);  // halted, not running.
    read_expect("retired", addr_retired, 32'(n_exec));
    read_expect("pc", addr_pc, 32'(halt_addr + 1));
  endtask

  // op 0 add, 1 adc, 2 sub.
  task automatic arith_case(input int op, input int r, input int q, input logic imm_form,
                            input logic dec);
    logic [3:0]  st[4];
    logic [7:0]  xa;
    logic [7:0]  ya;
    logic [3:0]  imm;
    logic [3:0]  opa;
    logic [3:0]  opb;
    logic [3:0]  res;
    logic [4:0]  full;
    logic [11:0] op_word;
    logic        cin;
    logic        c;
    xa = 8'(take_bits(8));
    ya = {~xa[7], xa[6:0]};
    for (int k = 0; k < 4; k++) begin
      st[k] = operand_value(dec);
    end
    imm = operand_value(dec);
    cin = 1'(take_bits(1));
    if (imm_form) op_word = 12'hC00 | 12'(op << 6) | 12'(r << 4) | 12'(imm);
    else op_word = 12'hA80 | 12'(op << 4) | 12'(r << 2) | 12'(q);
    prog_words = '{12'hF57, 12'hF40 | {9'b0, dec, 1'b0, cin}, 12'hB00 | 12'(xa),
                   12'h800 | 12'(ya), 12'hE00 | 12'(st[0]), 12'hE10 | 12'(st[1]),
                   12'hE20 | 12'(st[2]), 12'hE30 | 12'(st[3]), op_word, 12'hFF8};
    opa = st[r];
    opb = imm_form ? imm : st[q];
    if (op == 2) begin
      full = 5'(opa) - 5'(opb);
      c    = full[4];
      res  = full[3:0];
      if (dec && c) res = res + 4'd10;  // borrow wraps to the next decade.
    end else begin
      full = 5'(opa) + 5'(opb) + 5'(op == 1 && cin);
      c    = full[4];
      res  = full[3:0];
      if (dec && full > 5'd9) begin
        c   = 1'b1;
        res = 4'(full - 5'd10);
      end
    end
    st[r] = res;
    load_program();
    apb_write(addr_ctrl, 32'h1);
    wait_halt();
    check_end(10, 9);
    read_expect("A", addr_ab, {24'h0, st[1], st[0]});
    read_expect("M(X)", addr_data_base + {2'b0, xa, 2'b0}, 32'(st[2]));
    read_expect("M(Y)", addr_data_base + {2'b0, ya, 2'b0}, 32'(st[3]));
    read_expect("flags", addr_flags, {29'h0, dec, res == 4'h0, c});
    read_expect("X", addr_x, 32'(xa));
    read_expect("Y", addr_y, 32'(ya));
  endtask

  initial begin
    logic [31:0] rd;
    logic        err;
    int          t;
    rst_n   = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    for (int k = 0; k < 8; k++) begin
      read_expect($sformatf("reg %h after reset", 12'(k * 4)), 12'(k * 4), 32'h0);
    end

    for (int dec = 0; dec < 2; dec++) begin
      for (int op = 0; op < 3; op++) begin
        for (int r = 0; r < 4; r++) begin
          for (int q = 0; q < 4; q++) begin
            arith_case(op, r, q, 1'b0, dec[0]);
          end
          if (op < 2) arith_case(op, r, 0, 1'b1, dec[0]);
        end
      end
    end

    // jump over three words.
    prog_words = '{12'hE01, 12'h005, 12'hE07, 12'hE07, 12'hE07, 12'hE13, 12'hFF8};
    load_program();
    apb_write(addr_ctrl, 32'h1);
    wait_halt();
    check_end(4, 6);
    read_expect("A", addr_ab, 32'h31);

    apb_write(addr_data_base + 12'h154, 32'h9);
    apb_write(addr_prog_base + 12'h320, 32'h123);
    prog_words = '{12'hE01, 12'hE02, 12'hE03, 12'hE04, 12'hE05, 12'hE06, 12'hE07,
                   12'hE08, 12'hFF8};
    load_program();
    apb_write(addr_ctrl, 32'h1);
    t = 0;
    foreach (probe_pts[k]) begin
      repeat (probe_pts[k] - 1 - t) @(negedge clk);
      read_expect("retired", addr_retired, 32'(probe_pts[k] / cycles_per_instr));
      t = probe_pts[k] + 2;
    end
    apb_access(1'b1, addr_data_base + 12'h154, 32'h3, rd, err);
    check_value("pslverr", 32'h1, 32'(err));
    apb_access(1'b0, addr_data_base + 12'h154, 32'h0, rd, err);
    check_value("pslverr", 32'h1, 32'(err));
    apb_access(1'b1, addr_prog_base + 12'h320, 32'h456, rd, err);
    check_value("pslverr", 32'h1, 32'(err));
    read_expect("status", addr_status, 32'h1);
    wait_halt();
    check_end(9, 8);
    read_expect("M(0x55)", addr_data_base + 12'h154, 32'h9);
    read_expect("prog(200)", addr_prog_base + 12'h320, 32'h123);

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: e0c_cpu.f
rtl/e0c_pkg.sv
rtl/e0c_mem_if.sv
rtl/e0c_mem.sv
rtl/e0c_alu.sv
rtl/e0c_regs.sv
rtl/e0c_core.sv
rtl/e0c_apb_host.sv
rtl/e0c_cpu.sv
tests/e0c_cpu_tb.sv
